// File: common/interconnect_defs.svh
`ifndef INTERCONNECT_DEFS_SVH
`define INTERCONNECT_DEFS_SVH

////////////////////////////////////////
// Port counts
////////////////////////////////////////

// Number of TCDM master ports on the interconnect
`define SOC_IC_NR_MASTERS 2

// Number of word-interleaved SRAM banks
`define SOC_IC_NR_BANKS 4

// Banks plus the single contiguous slave port
`define SOC_IC_NR_TARGETS 5

////////////////////////////////////////
// Bus widths
////////////////////////////////////////

`define SOC_IC_ADDR_W 32
`define SOC_IC_DATA_W 32

// One byte enable per data byte
`define SOC_IC_BE_W (`SOC_IC_DATA_W / 8)

////////////////////////////////////////
// Fixed address map
////////////////////////////////////////

// Interleaved window of 64 KiB spread over all banks
`define SOC_IC_INTL_BASE 32'h1C00_0000
`define SOC_IC_INTL_SIZE 32'h0001_0000

// Contiguous window of 4 KiB behind the single slave port
`define SOC_IC_CONTIG_BASE 32'h1A10_0000
`define SOC_IC_CONTIG_SIZE 32'h0000_1000

// Read data returned for any access outside both windows
`define SOC_IC_ERR_WORD 32'hBADA_CCE5

`endif

// File: common/tcdm_pkg.sv
`include "interconnect_defs.svh"

package tcdm_pkg;

    ////////////////////////////////////////
    // Request side
    ////////////////////////////////////////

    // One master request as it travels through the crossbar
    // The write enable keeps the TCDM polarity, so 0 means write
    typedef struct packed {
        logic [`SOC_IC_ADDR_W-1:0] add;
        logic                      wen;
        logic [`SOC_IC_DATA_W-1:0] wdata;
        logic [`SOC_IC_BE_W-1:0]   be;
    } tcdm_req_t;

    ////////////////////////////////////////
    // Response side
    ////////////////////////////////////////

    // One response towards a master
    // The opc bit flags a bus error from the error responder
    typedef struct packed {
        logic                      r_valid;
        logic [`SOC_IC_DATA_W-1:0] r_rdata;
        logic                      r_opc;
    } tcdm_rsp_t;

    // Index of a master port, used by the grant records
    typedef logic [$clog2(`SOC_IC_NR_MASTERS)-1:0] master_idx_t;

endpackage

// File: common/addr_map_pkg.sv
`include "interconnect_defs.svh"

package addr_map_pkg;

    ////////////////////////////////////////
    // Target numbering
    ////////////////////////////////////////

    // Targets 0 up to NR_BANKS-1 are the interleaved banks
    // The contiguous slave sits right after the last bank
    typedef logic [$clog2(`SOC_IC_NR_TARGETS)-1:0] target_idx_t;

    // Target number of the contiguous slave port
    localparam target_idx_t CONTIG_TARGET = target_idx_t'(`SOC_IC_NR_BANKS);

    ////////////////////////////////////////
    // Decode result
    ////////////////////////////////////////

    // Region that an address falls into
    // Unmapped addresses never reach an arbiter
    typedef enum logic [1:0] {
        REGION_INTL     = 2'd0,
        REGION_CONTIG   = 2'd1,
        REGION_UNMAPPED = 2'd2
    } region_e;

endpackage

// File: common/xbar_req_if.sv
`timescale 1ns/1ps

`include "interconnect_defs.svh"

// Routed requests from the router towards the per-target arbiters
// Every arbiter sees the requests of all masters and picks the ones
// that name its own target
interface xbar_req_if;

    // Request strobe, only raised for addresses inside a mapped window
    logic [`SOC_IC_NR_MASTERS-1:0] req;

    // Target chosen by the address decoder, one per master
    addr_map_pkg::target_idx_t [`SOC_IC_NR_MASTERS-1:0] target;

    // Unchanged request fields of each master
    tcdm_pkg::tcdm_req_t [`SOC_IC_NR_MASTERS-1:0] payload;

    // Grant per master, the OR of all per-target grant vectors
    logic [`SOC_IC_NR_MASTERS-1:0] gnt;

    // The router drives the request side and watches the grants
    modport router (
        output req,
        output target,
        output payload,
        input  gnt
    );

    // Arbiters only listen, their grants leave as separate vectors
    modport arbiter (
        input req,
        input target,
        input payload
    );

endinterface

// File: src/tcdm_router.sv
`timescale 1ns/1ps

`include "interconnect_defs.svh"

// Address decoder in front of the crossbar
// Mapped requests go to the arbiters, unmapped ones are answered here
module tcdm_router (
    input  logic                                         clk_i,
    input  logic                                         arst_n_i,
    input  logic [`SOC_IC_NR_MASTERS-1:0]                m_req_i,
    input  tcdm_pkg::tcdm_req_t [`SOC_IC_NR_MASTERS-1:0] m_payload_i,
    xbar_req_if.router                                   req_bus,
    output logic [`SOC_IC_NR_MASTERS-1:0]                err_valid_o,
    output logic [`SOC_IC_NR_MASTERS-1:0]                m_gnt_o
);

    localparam int unsigned BANK_SEL_W = $clog2(`SOC_IC_NR_BANKS);

    addr_map_pkg::region_e [`SOC_IC_NR_MASTERS-1:0] region;

    // Requests that hit no window and are granted by the router itself
    logic [`SOC_IC_NR_MASTERS-1:0] err_gnt;

    ////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////

    always_comb begin
        logic [`SOC_IC_ADDR_W-1:0] addr;
        addr = '0;
        for (int m = 0; m < `SOC_IC_NR_MASTERS; m++) begin
            addr = m_payload_i[m].add;
            // Both windows are checked as half-open ranges
            if (addr >= `SOC_IC_INTL_BASE &&
                addr < (`SOC_IC_INTL_BASE + `SOC_IC_INTL_SIZE)) begin
                region[m] = addr_map_pkg::REGION_INTL;
            end else if (addr >= `SOC_IC_CONTIG_BASE &&
                         addr < (`SOC_IC_CONTIG_BASE + `SOC_IC_CONTIG_SIZE)) begin
                region[m] = addr_map_pkg::REGION_CONTIG;
            end else begin
                region[m] = addr_map_pkg::REGION_UNMAPPED;
            end

            // Word address bits pick the bank, so bits 1:0 are skipped
            if (region[m] == addr_map_pkg::REGION_INTL) begin
                req_bus.target[m] = addr_map_pkg::target_idx_t'(addr[BANK_SEL_W+1:2]);
            end else begin
                req_bus.target[m] = addr_map_pkg::CONTIG_TARGET;
            end

            req_bus.req[m]     = m_req_i[m] && (region[m] != addr_map_pkg::REGION_UNMAPPED);
            req_bus.payload[m] = m_payload_i[m];
            err_gnt[m]         = m_req_i[m] && (region[m] == addr_map_pkg::REGION_UNMAPPED);
        end
    end

    ////////////////////////////////////////
    // Grants and error responder
    ////////////////////////////////////////

    // At most one of the two terms can be set for a master
    assign m_gnt_o = req_bus.gnt | err_gnt;

    // The error answer follows its grant by exactly one cycle
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            err_valid_o <= '0;
        end else begin
            err_valid_o <= err_gnt;
        end
    end

    // An arbiter grant must always belong to a mapped request
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (req_bus.gnt & ~req_bus.req) == '0);

endmodule

// File: xbar/target_arbiter.sv
`timescale 1ns/1ps

`include "interconnect_defs.svh"

// Round-robin arbiter for one target port
// One instance exists per bank and one for the contiguous slave
module target_arbiter #(
    parameter addr_map_pkg::target_idx_t TARGET_ID = '0
) (
    input  logic                          clk_i,
    input  logic                          arst_n_i,
    xbar_req_if.arbiter                   req_bus,
    output logic                          s_req_o,
    output tcdm_pkg::tcdm_req_t           s_payload_o,
    input  logic                          s_gnt_i,
    output logic [`SOC_IC_NR_MASTERS-1:0] gnt_vec_o,
    output logic                          rec_valid_o,
    output tcdm_pkg::master_idx_t         rec_master_o
);

    // Masters whose current request names this target
    logic [`SOC_IC_NR_MASTERS-1:0] hit;

    // Master with the highest priority in the next search
    tcdm_pkg::master_idx_t rr_q;

    tcdm_pkg::master_idx_t winner;
    tcdm_pkg::master_idx_t rr_next;
    logic                  any_hit;
    logic                  accept;

    always_comb begin
        for (int m = 0; m < `SOC_IC_NR_MASTERS; m++) begin
            hit[m] = req_bus.req[m] && (req_bus.target[m] == TARGET_ID);
        end
    end

    ////////////////////////////////////////
    // Round-robin search
    ////////////////////////////////////////

    // Walk from the farthest offset down to the pointer itself
    // so the requester closest to the pointer wins
    always_comb begin
        int idx;
        idx     = 0;
        winner  = rr_q;
        any_hit = 1'b0;
        for (int k = `SOC_IC_NR_MASTERS - 1; k >= 0; k--) begin
            idx = (int'(rr_q) + k) % `SOC_IC_NR_MASTERS;
            if (hit[idx]) begin
                winner  = tcdm_pkg::master_idx_t'(idx);
                any_hit = 1'b1;
            end
        end
    end

    assign rr_next = tcdm_pkg::master_idx_t'((int'(winner) + 1) % `SOC_IC_NR_MASTERS);

    ////////////////////////////////////////
    // Slave port and grants
    ////////////////////////////////////////

    assign s_req_o     = any_hit;
    assign s_payload_o = req_bus.payload[winner];
    assign accept      = any_hit && s_gnt_i;

    // Only the winner sees a grant, and only if the slave takes it
    always_comb begin
        gnt_vec_o         = '0;
        gnt_vec_o[winner] = accept;
    end

    // The record tells the response path who owns next cycle's data
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rr_q         <= '0;
            rec_valid_o  <= 1'b0;
            rec_master_o <= '0;
        end else begin
            rec_valid_o  <= accept;
            rec_master_o <= winner;
            // Pointer only moves on accepted grants so a stalled winner keeps its turn
            if (accept) begin
                rr_q <= rr_next;
            end
        end
    end

    // At most one grant, and it goes to a master that asks for this target
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $onehot0(gnt_vec_o) && ((gnt_vec_o & ~hit) == '0));

endmodule

// File: xbar/resp_return.sv
`timescale 1ns/1ps

`include "interconnect_defs.svh"

// Response path back to the masters
// Every slave answers one cycle after its grant, so the grant records
// of the arbiters are enough to steer the read data
module resp_return (
    input  logic [`SOC_IC_NR_TARGETS-1:0]                           rec_valid_i,
    input  tcdm_pkg::master_idx_t [`SOC_IC_NR_TARGETS-1:0]          rec_master_i,
    input  logic [`SOC_IC_NR_TARGETS-1:0][`SOC_IC_DATA_W-1:0]       s_rdata_i,
    input  logic [`SOC_IC_NR_MASTERS-1:0]                           err_valid_i,
    input  logic                                                    clk_i,
    input  logic                                                    arst_n_i,
    output tcdm_pkg::tcdm_rsp_t [`SOC_IC_NR_MASTERS-1:0]            m_rsp_o
);

    // Which target records name which master in this cycle
    logic [`SOC_IC_NR_MASTERS-1:0][`SOC_IC_NR_TARGETS-1:0] hit_map;

    ////////////////////////////////////////
    // Data steering
    ////////////////////////////////////////

    always_comb begin
        for (int m = 0; m < `SOC_IC_NR_MASTERS; m++) begin
            m_rsp_o[m] = '0;
            for (int t = 0; t < `SOC_IC_NR_TARGETS; t++) begin
                hit_map[m][t] = rec_valid_i[t] &&
                                (rec_master_i[t] == tcdm_pkg::master_idx_t'(m));
                // AND-OR mux, only one term is expected to be live
                m_rsp_o[m].r_rdata = m_rsp_o[m].r_rdata |
                                     (s_rdata_i[t] & {`SOC_IC_DATA_W{hit_map[m][t]}});
            end
            m_rsp_o[m].r_valid = |hit_map[m];

            // Error answers come from the router, never from a slave
            if (err_valid_i[m]) begin
                m_rsp_o[m].r_valid = 1'b1;
                m_rsp_o[m].r_rdata = `SOC_IC_ERR_WORD;
                m_rsp_o[m].r_opc   = 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    for (genvar m = 0; m < `SOC_IC_NR_MASTERS; m++) begin : gen_checks
        // A master holds one request at a time, so two targets cannot
        // have granted it in the same cycle
        assert property (@(posedge clk_i) disable iff (!arst_n_i)
            $onehot0(hit_map[m]));

        // Router and arbiters never grant the same master together
        assert property (@(posedge clk_i) disable iff (!arst_n_i)
            !(err_valid_i[m] && (|hit_map[m])));
    end

endmodule

// File: src/soc_interconnect.sv
`timescale 1ns/1ps

`include "interconnect_defs.svh"

// TCDM interconnect top with interleaved banks, one contiguous slave
// and a built-in error responder for unmapped addresses
module soc_interconnect (
    input  logic                                               clk_i,
    input  logic                                               arst_n_i,
    // Master ports
    input  logic [`SOC_IC_NR_MASTERS-1:0]                      m_req_i,
    input  logic [`SOC_IC_NR_MASTERS-1:0][`SOC_IC_ADDR_W-1:0]  m_add_i,
    input  logic [`SOC_IC_NR_MASTERS-1:0]                      m_wen_i,
    input  logic [`SOC_IC_NR_MASTERS-1:0][`SOC_IC_DATA_W-1:0]  m_wdata_i,
    input  logic [`SOC_IC_NR_MASTERS-1:0][`SOC_IC_BE_W-1:0]    m_be_i,
    output logic [`SOC_IC_NR_MASTERS-1:0]                      m_gnt_o,
    output logic [`SOC_IC_NR_MASTERS-1:0]                      m_r_valid_o,
    output logic [`SOC_IC_NR_MASTERS-1:0][`SOC_IC_DATA_W-1:0]  m_r_rdata_o,
    output logic [`SOC_IC_NR_MASTERS-1:0]                      m_r_opc_o,
    // Target ports, banks first and the contiguous slave last
    output logic [`SOC_IC_NR_TARGETS-1:0]                      s_req_o,
    output logic [`SOC_IC_NR_TARGETS-1:0][`SOC_IC_ADDR_W-1:0]  s_add_o,
    output logic [`SOC_IC_NR_TARGETS-1:0]                      s_wen_o,
    output logic [`SOC_IC_NR_TARGETS-1:0][`SOC_IC_DATA_W-1:0]  s_wdata_o,
    output logic [`SOC_IC_NR_TARGETS-1:0][`SOC_IC_BE_W-1:0]    s_be_o,
    input  logic [`SOC_IC_NR_TARGETS-1:0]                      s_gnt_i,
    input  logic [`SOC_IC_NR_TARGETS-1:0][`SOC_IC_DATA_W-1:0]  s_rdata_i
);

    xbar_req_if req_bus ();

    tcdm_pkg::tcdm_req_t [`SOC_IC_NR_MASTERS-1:0] m_payload;
    tcdm_pkg::tcdm_rsp_t [`SOC_IC_NR_MASTERS-1:0] m_rsp;
    tcdm_pkg::tcdm_req_t [`SOC_IC_NR_TARGETS-1:0] s_payload;

    logic [`SOC_IC_NR_TARGETS-1:0][`SOC_IC_NR_MASTERS-1:0] gnt_vec;
    logic [`SOC_IC_NR_TARGETS-1:0]                         rec_valid;
    tcdm_pkg::master_idx_t [`SOC_IC_NR_TARGETS-1:0]        rec_master;
    logic [`SOC_IC_NR_MASTERS-1:0]                         err_valid;

    ////////////////////////////////////////
    // Master side packing
    ////////////////////////////////////////

    for (genvar m = 0; m < `SOC_IC_NR_MASTERS; m++) begin : gen_master_pack
        assign m_payload[m] = '{
            add:   m_add_i[m],
            wen:   m_wen_i[m],
            wdata: m_wdata_i[m],
            be:    m_be_i[m]
        };
        assign m_r_valid_o[m] = m_rsp[m].r_valid;
        assign m_r_rdata_o[m] = m_rsp[m].r_rdata;
        assign m_r_opc_o[m]   = m_rsp[m].r_opc;
    end

    tcdm_router i_router (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .m_req_i     (m_req_i),
        .m_payload_i (m_payload),
        .req_bus     (req_bus),
        .err_valid_o (err_valid),
        .m_gnt_o     (m_gnt_o)
    );

    ////////////////////////////////////////
    // Per-target arbitration
    ////////////////////////////////////////

    for (genvar t = 0; t < `SOC_IC_NR_TARGETS; t++) begin : gen_target
        target_arbiter #(
            .TARGET_ID (addr_map_pkg::target_idx_t'(t))
        ) i_arbiter (
            .clk_i        (clk_i),
            .arst_n_i     (arst_n_i),
            .req_bus      (req_bus),
            .s_req_o      (s_req_o[t]),
            .s_payload_o  (s_payload[t]),
            .s_gnt_i      (s_gnt_i[t]),
            .gnt_vec_o    (gnt_vec[t]),
            .rec_valid_o  (rec_valid[t]),
            .rec_master_o (rec_master[t])
        );

        assign s_add_o[t]   = s_payload[t].add;
        assign s_wen_o[t]   = s_payload[t].wen;
        assign s_wdata_o[t] = s_payload[t].wdata;
        assign s_be_o[t]    = s_payload[t].be;
    end

    // A master asks one target at a time, so the OR merges at most one grant
    always_comb begin
        req_bus.gnt = '0;
        for (int t = 0; t < `SOC_IC_NR_TARGETS; t++) begin
            req_bus.gnt = req_bus.gnt | gnt_vec[t];
        end
    end

    ////////////////////////////////////////
    // Response return
    ////////////////////////////////////////

    resp_return i_resp_return (
        .rec_valid_i  (rec_valid),
        .rec_master_i (rec_master),
        .s_rdata_i    (s_rdata_i),
        .err_valid_i  (err_valid),
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .m_rsp_o      (m_rsp)
    );

endmodule

// File: testbench/tb_soc_interconnect.sv
`timescale 1ns/1ps

`include "interconnect_defs.svh"

// Testbench for the TCDM interconnect with LFSR driven masters and
// one-cycle slave models, all checking is done by the assertions below
module tb_soc_interconnect;

    localparam int unsigned NR_M        = `SOC_IC_NR_MASTERS;
    localparam int unsigned NR_T        = `SOC_IC_NR_TARGETS;
    localparam int unsigned PL_W        = `SOC_IC_ADDR_W + 1 + `SOC_IC_DATA_W + `SOC_IC_BE_W;
    localparam int unsigned N_MIXED     = 60;
    localparam int unsigned N_CONTEND   = 20;
    localparam int unsigned N_ERR       = 8;
    localparam int unsigned PLANNED     = N_MIXED + N_CONTEND + N_ERR;
    localparam int unsigned CYCLE_LIMIT = 12 * PLANNED;

    // Stimulus modes and decode results of the reference model
    localparam int unsigned MODE_IDLE    = 0;
    localparam int unsigned MODE_MIXED   = 1;
    localparam int unsigned MODE_CONTEND = 2;
    localparam int unsigned MODE_ERR     = 3;
    localparam int unsigned REG_INTL     = 0;
    localparam int unsigned REG_CONTIG   = 1;
    localparam int unsigned REG_NONE     = 2;

    logic                                      clk_i     = 1'b0;
    logic                                      arst_n_i  = 1'b0;
    logic [NR_M-1:0]                           m_req_i   = '0;
    logic [NR_M-1:0][`SOC_IC_ADDR_W-1:0]       m_add_i   = '0;
    logic [NR_M-1:0]                           m_wen_i   = '1;
    logic [NR_M-1:0][`SOC_IC_DATA_W-1:0]       m_wdata_i = '0;
    logic [NR_M-1:0][`SOC_IC_BE_W-1:0]         m_be_i    = '0;
    logic [NR_T-1:0]                           s_gnt_i   = '0;
    logic [NR_T-1:0][`SOC_IC_DATA_W-1:0]       s_rdata_i = '0;
    logic [NR_M-1:0]                           m_gnt_o;
    logic [NR_M-1:0]                           m_r_valid_o;
    logic [NR_M-1:0][`SOC_IC_DATA_W-1:0]       m_r_rdata_o;
    logic [NR_M-1:0]                           m_r_opc_o;
    logic [NR_T-1:0]                           s_req_o;
    logic [NR_T-1:0][`SOC_IC_ADDR_W-1:0]       s_add_o;
    logic [NR_T-1:0]                           s_wen_o;
    logic [NR_T-1:0][`SOC_IC_DATA_W-1:0]       s_wdata_o;
    logic [NR_T-1:0][`SOC_IC_BE_W-1:0]         s_be_o;

    // Reference model, combinational part
    int unsigned     tgt [NR_M];
    logic [NR_M-1:0] mapped;
    logic [NR_M-1:0] tgt_sgnt;
    logic [PL_W-1:0] sent [NR_M];
    logic [PL_W-1:0] routed [NR_M];
    logic [NR_T-1:0] exp_sreq;
    logic [NR_T-1:0] contend;
    int unsigned     gnt_cnt [NR_T];
    int unsigned     req_cnt [NR_T];
    int unsigned     win [NR_T];

    // Reference model state, updated in the middle of each cycle
    logic [NR_M-1:0]                 pend_rv   = '0;
    logic [NR_M-1:0]                 pend_opc  = '0;
    logic [NR_M-1:0]                 exp_rv    = '0;
    logic [NR_M-1:0]                 exp_opc   = '0;
    logic [NR_M-1:0]                 gnt_seen  = '0;
    logic [`SOC_IC_DATA_W-1:0]       pend_rdata [NR_M];
    logic [`SOC_IC_DATA_W-1:0]       exp_rdata [NR_M];
    logic [NR_T-1:0]                 s_pend    = '0;
    logic [`SOC_IC_DATA_W-1:0]       s_pend_word [NR_T];
    logic [NR_T-1:0]                 last_valid = '0;
    logic [NR_T-1:0]                 prev_valid = '0;
    int unsigned                     last_win [NR_T];
    int unsigned                     prev_win [NR_T];
    int unsigned                     grant_cnt = 0;
    int unsigned                     err_cnt   = 0;
    int unsigned                     cycle_cnt = 0;
    logic [31:0]                     lfsr      = 32'd32;

    soc_interconnect u_dut (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .m_req_i     (m_req_i),
        .m_add_i     (m_add_i),
        .m_wen_i     (m_wen_i),
        .m_wdata_i   (m_wdata_i),
        .m_be_i      (m_be_i),
        .m_gnt_o     (m_gnt_o),
        .m_r_valid_o (m_r_valid_o),
        .m_r_rdata_o (m_r_rdata_o),
        .m_r_opc_o   (m_r_opc_o),
        .s_req_o     (s_req_o),
        .s_add_o     (s_add_o),
        .s_wen_o     (s_wen_o),
        .s_wdata_o   (s_wdata_o),
        .s_be_o      (s_be_o),
        .s_gnt_i     (s_gnt_i),
        .s_rdata_i   (s_rdata_i)
    );

    always #10 clk_i = ~clk_i;

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic int unsigned region_of(input logic [31:0] a);
        if (a >= `SOC_IC_INTL_BASE && a < `SOC_IC_INTL_BASE + `SOC_IC_INTL_SIZE) begin
            return REG_INTL;
        end
        if (a >= `SOC_IC_CONTIG_BASE && a < `SOC_IC_CONTIG_BASE + `SOC_IC_CONTIG_SIZE) begin
            return REG_CONTIG;
        end
        return REG_NONE;
    endfunction

    // Banks take word address bits 3:2, the contiguous slave is the last target
    function automatic int unsigned target_of(input logic [31:0] a);
        if (region_of(a) == REG_INTL) begin
            return 32'(a[3:2]);
        end
        return NR_T - 1;
    endfunction

    // Data word a slave model answers with
    function automatic logic [31:0] slave_word(input int unsigned t, input logic [31:0] a);
        return {4'hA, t[3:0], a[23:0]};
    endfunction

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int unsigned n, output logic [31:0] v);
        v = '0;
        for (int unsigned i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic new_request(input int unsigned mode, input int unsigned m);
        logic [31:0] r;
        logic [31:0] sel;
        logic [31:0] addr;
        r   = '0;
        sel = 32'd3;
        if (mode == MODE_MIXED) begin
            take_bits(2, r);
            take_bits(2, sel);
        end
        if (mode == MODE_IDLE || (mode == MODE_MIXED && r[1:0] == 2'b00)) begin
            m_req_i[m] = 1'b0;
            return;
        end
        if (mode == MODE_CONTEND) begin
            // Every contending request lands on bank 2
            take_bits(12, r);
            addr = `SOC_IC_INTL_BASE + (r << 4) + 32'h8;
        end else if (sel < 2) begin
            take_bits(14, r);
            addr = `SOC_IC_INTL_BASE + (r << 2);
        end else if (sel == 2) begin
            take_bits(10, r);
            addr = `SOC_IC_CONTIG_BASE + (r << 2);
        end else begin
            // Unmapped words just outside one of the two window edges
            take_bits(5, r);
            if (r[4]) begin
                addr = `SOC_IC_INTL_BASE + `SOC_IC_INTL_SIZE + {26'd0, r[3:0], 2'b00};
            end else begin
                addr = `SOC_IC_CONTIG_BASE - 32'h4 - {26'd0, r[3:0], 2'b00};
            end
        end
        m_add_i[m] = addr;
        take_bits(1, r);
        m_wen_i[m] = r[0];
        take_bits(32, r);
        m_wdata_i[m] = r;
        take_bits(4, r);
        m_be_i[m]  = r[3:0];
        m_req_i[m] = 1'b1;
    endtask

    // One clock cycle of master and slave-grant stimulus
    task automatic drive_cycle(input int unsigned mode);
        logic [31:0] r;
        r = '0;
        @(posedge clk_i);
        #2;
        for (int unsigned m = 0; m < NR_M; m++) begin
            // A request stays on the bus until it has been granted
            if (!m_req_i[m] || gnt_seen[m]) begin
                new_request(mode, m);
            end
        end
        for (int unsigned t = 0; t < NR_T; t++) begin
            take_bits(2, r);
            s_gnt_i[t] = (mode != MODE_MIXED) || (r[1:0] != 2'b00);
        end
    endtask

    task automatic run_phase(input int unsigned mode, input int unsigned count);
        int unsigned goal;
        goal = grant_cnt + count;
        while (grant_cnt < goal) begin
            drive_cycle(mode);
        end
    endtask

    ////////////////////////////////////////
    // Reference model and slave models
    ////////////////////////////////////////

    always_comb begin
        for (int unsigned t = 0; t < NR_T; t++) begin
            gnt_cnt[t] = 0;
            req_cnt[t] = 0;
            win[t]     = 0;
        end
        for (int unsigned m = 0; m < NR_M; m++) begin
            tgt[m]      = target_of(m_add_i[m]);
            mapped[m]   = region_of(m_add_i[m]) != REG_NONE;
            tgt_sgnt[m] = s_gnt_i[tgt[m]];
            sent[m]     = {m_add_i[m], m_wen_i[m], m_wdata_i[m], m_be_i[m]};
            routed[m]   = {s_add_o[tgt[m]], s_wen_o[tgt[m]], s_wdata_o[tgt[m]], s_be_o[tgt[m]]};
            if (m_req_i[m] && mapped[m]) begin
                req_cnt[tgt[m]]++;
            end
            if (m_gnt_o[m] && mapped[m]) begin
                gnt_cnt[tgt[m]]++;
                win[tgt[m]] = m;
            end
        end
        for (int unsigned t = 0; t < NR_T; t++) begin
            exp_sreq[t] = req_cnt[t] != 0;
            contend[t]  = req_cnt[t] == NR_M;
        end
    end

    // Records what was granted, in the middle of the cycle where all is stable
    always @(negedge clk_i) begin
        if (!arst_n_i) begin
            pend_rv    = '0;
            exp_rv     = '0;
            gnt_seen   = '0;
            s_pend     = '0;
            last_valid = '0;
            prev_valid = '0;
        end else begin
            for (int unsigned m = 0; m < NR_M; m++) begin
                exp_rv[m]     = pend_rv[m];
                exp_opc[m]    = pend_opc[m];
                exp_rdata[m]  = pend_rdata[m];
                pend_rv[m]    = m_gnt_o[m];
                pend_opc[m]   = !mapped[m];
                pend_rdata[m] = mapped[m] ? slave_word(tgt[m], m_add_i[m]) : `SOC_IC_ERR_WORD;
                gnt_seen[m]   = m_gnt_o[m];
                if (m_gnt_o[m]) begin
                    grant_cnt++;
                end
            end
            for (int unsigned t = 0; t < NR_T; t++) begin
                prev_win[t]    = last_win[t];
                prev_valid[t]  = last_valid[t];
                s_pend[t]      = s_req_o[t] && s_gnt_i[t];
                s_pend_word[t] = slave_word(t, s_add_o[t]);
                if (gnt_cnt[t] != 0) begin
                    last_win[t]   = win[t];
                    last_valid[t] = 1'b1;
                end
            end
        end
    end

    // Each slave answers in the cycle after it granted, junk otherwise
    always @(posedge clk_i) begin
        #2;
        for (int unsigned t = 0; t < NR_T; t++) begin
            s_rdata_i[t] = s_pend[t] ? s_pend_word[t] : (32'hDEAD_0000 | 32'(t));
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    for (genvar m = 0; m < NR_M; m++) begin : gen_master_chk
        assert property (@(posedge clk_i) disable iff (!arst_n_i)
            m_gnt_o[m] && mapped[m] |-> routed[m] == sent[m])
        else begin
            err_cnt++;
            $display("[ERROR] routing m%0d: expected %h actual %h",
                     m, $sampled(sent[m]), $sampled(routed[m]));
        end

        assert property (@(posedge clk_i) disable iff (!arst_n_i)
            m_req_i[m] && !mapped[m] |-> m_gnt_o[m])
        else begin
            err_cnt++;
            $display("[ERROR] error_grant m%0d: expected 1 actual %b", m, $sampled(m_gnt_o[m]));
        end

        // A grant needs a request, and a mapped one needs its slave ready
        assert property (@(posedge clk_i) disable iff (!arst_n_i)
            m_gnt_o[m] |-> m_req_i[m] && (!mapped[m] || tgt_sgnt[m]))
        else begin
            err_cnt++;
            $display("Master %0d was granted without a request or while its slave stalled", m);
        end

        assert property (@(posedge clk_i) disable iff (!arst_n_i)
            m_r_valid_o[m] == exp_rv[m])
        else begin
            err_cnt++;
            $display("[ERROR] response_valid m%0d: expected %b actual %b",
                     m, exp_rv[m], $sampled(m_r_valid_o[m]));
        end

        assert property (@(posedge clk_i) disable iff (!arst_n_i)
            exp_rv[m] |-> {m_r_opc_o[m], m_r_rdata_o[m]} == {exp_opc[m], exp_rdata[m]})
        else begin
            err_cnt++;
            $display("[ERROR] %s m%0d: expected %h actual %h",
                     exp_opc[m] ? "error_response" : "read_return", m,
                     {exp_opc[m], exp_rdata[m]}, $sampled({m_r_opc_o[m], m_r_rdata_o[m]}));
        end
    end

    for (genvar t = 0; t < NR_T; t++) begin : gen_target_chk
        // Only targets named by a mapped request may be requested
        assert property (@(posedge clk_i) disable iff (!arst_n_i)
            s_req_o[t] == exp_sreq[t])
        else begin
            err_cnt++;
            $display("[ERROR] target_request t%0d: expected %b actual %b",
                     t, exp_sreq[t], $sampled(s_req_o[t]));
        end

        assert property (@(posedge clk_i) disable iff (!arst_n_i)
            gnt_cnt[t] == ((exp_sreq[t] && s_gnt_i[t]) ? 1 : 0))
        else begin
            err_cnt++;
            $display("[ERROR] arbitration t%0d: expected %0d grants actual %0d",
                     t, (exp_sreq[t] && s_gnt_i[t]) ? 1 : 0, $sampled(gnt_cnt[t]));
        end

        assert property (@(posedge clk_i) disable iff (!arst_n_i)
            contend[t] && s_gnt_i[t] && prev_valid[t] |-> win[t] != prev_win[t])
        else begin
            err_cnt++;
            $display("[ERROR] round_robin t%0d: expected master %0d actual %0d",
                     t, (prev_win[t] + 1) % NR_M, $sampled(win[t]));
        end
    end

    ////////////////////////////////////////
    // Sequence and watchdog
    ////////////////////////////////////////

    initial begin
        repeat (2) @(posedge clk_i);
        #2;
        arst_n_i = 1'b1;
        // A few idle cycles show the state right after reset
        repeat (3) drive_cycle(MODE_IDLE);
        run_phase(MODE_MIXED, N_MIXED);
        run_phase(MODE_CONTEND, N_CONTEND);
        run_phase(MODE_ERR, N_ERR);
        while (m_req_i != '0) begin
            drive_cycle(MODE_IDLE);
        end
        repeat (3) drive_cycle(MODE_IDLE);
        $display("Summary: %0d errors, %0d grants, %0d cycles", err_cnt, grant_cnt, cycle_cnt);
        if (err_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: tb.f
+incdir+common
common/tcdm_pkg.sv
common/addr_map_pkg.sv
common/xbar_req_if.sv
src/tcdm_router.sv
xbar/target_arbiter.sv
xbar/resp_return.sv
src/soc_interconnect.sv
testbench/tb_soc_interconnect.sv

// File: run.sh
#!/bin/sh
# Build and run the interconnect testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        -f tb.f --top-module tb_soc_interconnect -Mdir obj_dir -o sim_tb; then
    echo "Verilator build failed"
    exit 1
fi

if ! sim_out=$(./obj_dir/sim_tb); then
    printf '%s\n' "$sim_out"
    echo "Simulation exited with an error"
    exit 1
fi

printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx '>>> PASS'; then
    exit 0
fi

echo "Pass message not found in the simulation output"
exit 1
